// ==== source/rvv_cfg_pkg.sv ====
/* retire stage configuration
   widths, port counts, credit depth and the vector types built from them */
`default_nettype none

package rvv_cfg_pkg;

  localparam int NUM_RT_UOP   = 4;   // retire entries per cycle
  localparam int VLEN         = 64;
  localparam int VLENB        = VLEN / 8;
  localparam int XLEN         = 32;
  localparam int INDEX_WIDTH  = 5;
  localparam int VCSR_WIDTH   = 16;
  localparam int XRF_CREDITS  = 4;   // depth of the xrf sink queue
  localparam int CREDIT_WIDTH = 3;

  typedef logic [VLEN-1:0]         vdata_t;
  typedef logic [XLEN-1:0]         xdata_t;
  typedef logic [INDEX_WIDTH-1:0]  rf_index_t;
  typedef logic [VLENB-1:0]        strobe_t;
  typedef logic [2*VLENB-1:0]      vd_type_t;   // 2 bits per byte
  typedef logic [VCSR_WIDTH-1:0]   vcsr_t;
  typedef logic [CREDIT_WIDTH-1:0] credit_t;

endpackage

`default_nettype wire

// ==== source/rvv_uop_pkg.sv ====
/* micro-op field encodings seen at retire */
`default_nettype none

package rvv_uop_pkg;

  // element type code per byte
  localparam logic [1:0] ELEM_ACTIVE = 2'b11;   // byte carries a result

  // destination register file
  localparam logic DEST_VRF = 1'b0;
  localparam logic DEST_XRF = 1'b1;

endpackage

`default_nettype wire

// ==== source/retire_credit_counter.sv ====
/* xrf credit counter, grants credits to retiring scalar writes oldest first
   and forms the in-order accept mask */
`timescale 1ns/10ps
`default_nettype none

module retire_credit_counter (
  input  wire logic                                   clk,
  input  wire logic                                   reset,
  input  wire logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]     rob_valid,
  input  wire logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]     live,
  input  wire logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]     rob_dest_xrf,
  input  wire logic                                   xrf_credit_return,
  output logic      [rvv_cfg_pkg::NUM_RT_UOP-1:0]     accept
);

  rvv_cfg_pkg::credit_t credit_cnt;
  rvv_cfg_pkg::credit_t taken;     // credits granted this cycle
  logic                 chain_ok;  // all older entries retire
  logic                 need;

  //////////////////////////////
  // in-order grant walk
  //////////////////////////////
  always_comb begin
    chain_ok = 1'b1;
    taken    = '0;
    need     = 1'b0;
    for (int k = 0; k < rvv_cfg_pkg::NUM_RT_UOP; k++) begin
      need      = live[k] && (rob_dest_xrf[k] == rvv_uop_pkg::DEST_XRF);
      accept[k] = chain_ok && (!need || (taken < credit_cnt));
      if (accept[k] && need) begin
        taken = taken + 1'b1;
      end
      chain_ok = accept[k] && rob_valid[k];  // stop at first refusal or hole
    end
  end

  // returned credit only counts from next cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_cnt <= rvv_cfg_pkg::credit_t'(rvv_cfg_pkg::XRF_CREDITS);
    end else begin
      credit_cnt <= credit_cnt - taken + rvv_cfg_pkg::credit_t'(xrf_credit_return);
    end
  end

  a_cnt_bound : assert property (@(posedge clk) disable iff (reset)
    credit_cnt <= rvv_cfg_pkg::credit_t'(rvv_cfg_pkg::XRF_CREDITS));

  // sink cannot return more than it was given
  a_no_overreturn : assert property (@(posedge clk) disable iff (reset)
    !(xrf_credit_return &&
      (credit_cnt == rvv_cfg_pkg::credit_t'(rvv_cfg_pkg::XRF_CREDITS))));

endmodule

`default_nettype wire

// ==== source/retire_trap_filter.sv ====
/* trap filter, drops entries younger than the oldest trapping one
   and picks that entry's vcsr value */
`timescale 1ns/10ps
`default_nettype none

module retire_trap_filter (
  input  wire logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]        rob_valid,
  input  wire logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]        rob_trap,
  input  wire rvv_cfg_pkg::vcsr_t [rvv_cfg_pkg::NUM_RT_UOP-1:0] rob_vcsr,
  output logic      [rvv_cfg_pkg::NUM_RT_UOP-1:0]        live,
  output logic                                           trap_valid,
  output rvv_cfg_pkg::vcsr_t                             trap_vcsr
);

  logic trap_seen;  // an older valid entry trapped

  always_comb begin
    trap_seen  = 1'b0;
    trap_valid = 1'b0;
    trap_vcsr  = '0;
    for (int k = 0; k < rvv_cfg_pkg::NUM_RT_UOP; k++) begin
      live[k] = rob_valid[k] && !trap_seen;
      if (live[k] && rob_trap[k]) begin
        trap_valid = 1'b1;       // first hit is the oldest
        trap_vcsr  = rob_vcsr[k];
      end
      trap_seen = trap_seen || (rob_valid[k] && rob_trap[k]);
    end
  end

endmodule

`default_nettype wire

// ==== source/retire_strobe_gen.sv ====
/* vrf byte enables per retire entry
   element-type decode, agnostic override and same-cycle WAW masking */
`timescale 1ns/10ps
`default_nettype none

module retire_strobe_gen (
  input  wire rvv_cfg_pkg::vd_type_t  [rvv_cfg_pkg::NUM_RT_UOP-1:0] rob_vd_type,
  input  wire logic                   [rvv_cfg_pkg::NUM_RT_UOP-1:0] rob_ignore_vta,
  input  wire logic                   [rvv_cfg_pkg::NUM_RT_UOP-1:0] rob_ignore_vma,
  input  wire rvv_cfg_pkg::rf_index_t [rvv_cfg_pkg::NUM_RT_UOP-1:0] rob_index,
  input  wire logic                   [rvv_cfg_pkg::NUM_RT_UOP-1:0] vrf_write,
  output rvv_cfg_pkg::strobe_t        [rvv_cfg_pkg::NUM_RT_UOP-1:0] strobe
);

  rvv_cfg_pkg::strobe_t [rvv_cfg_pkg::NUM_RT_UOP-1:0] base_en;
  rvv_cfg_pkg::strobe_t [rvv_cfg_pkg::NUM_RT_UOP-1:0] waw_mask;  // bytes owned by younger

  //////////////////////////////
  // base enable per entry
  //////////////////////////////
  always_comb begin
    for (int k = 0; k < rvv_cfg_pkg::NUM_RT_UOP; k++) begin
      for (int b = 0; b < rvv_cfg_pkg::VLENB; b++) begin
        base_en[k][b] = (rob_vd_type[k][2*b +: 2] == rvv_uop_pkg::ELEM_ACTIVE);
      end
      // tail and mask both agnostic, whole register may be written
      if (rob_ignore_vta[k] && rob_ignore_vma[k]) begin
        base_en[k] = '1;
      end
    end
  end

  //////////////////////////////
  // write-after-write
  //////////////////////////////
  // any younger writer to the same register takes the byte
  always_comb begin
    for (int k = 0; k < rvv_cfg_pkg::NUM_RT_UOP; k++) begin
      waw_mask[k] = '0;
      for (int j = k + 1; j < rvv_cfg_pkg::NUM_RT_UOP; j++) begin
        if (vrf_write[j] && (rob_index[j] == rob_index[k])) begin
          waw_mask[k] = waw_mask[k] | base_en[j];
        end
      end
    end
  end

  assign strobe = base_en & ~waw_mask;  // youngest writer keeps each byte

endmodule

`default_nettype wire

// ==== source/retire_writeback_regs.sv ====
/* output registers for the vrf, xrf and vcsr write ports
   valids route each retired entry by destination */
`timescale 1ns/10ps
`default_nettype none

module retire_writeback_regs (
  input  wire logic                                               clk,
  input  wire logic                                               reset,
  input  wire logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                 accept,
  input  wire logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                 live,
  input  wire logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                 rob_dest_xrf,
  input  wire rvv_cfg_pkg::rf_index_t [rvv_cfg_pkg::NUM_RT_UOP-1:0] rob_index,
  input  wire rvv_cfg_pkg::vdata_t    [rvv_cfg_pkg::NUM_RT_UOP-1:0] rob_data,
  input  wire rvv_cfg_pkg::strobe_t   [rvv_cfg_pkg::NUM_RT_UOP-1:0] strobe,
  input  wire logic                                               trap_valid,
  input  wire rvv_cfg_pkg::vcsr_t                                 trap_vcsr,
  output logic      [rvv_cfg_pkg::NUM_RT_UOP-1:0]                 vrf_wr_valid,
  output rvv_cfg_pkg::rf_index_t [rvv_cfg_pkg::NUM_RT_UOP-1:0]    vrf_wr_index,
  output rvv_cfg_pkg::vdata_t    [rvv_cfg_pkg::NUM_RT_UOP-1:0]    vrf_wr_data,
  output rvv_cfg_pkg::strobe_t   [rvv_cfg_pkg::NUM_RT_UOP-1:0]    vrf_wr_strobe,
  output logic      [rvv_cfg_pkg::NUM_RT_UOP-1:0]                 xrf_wr_valid,
  output rvv_cfg_pkg::rf_index_t [rvv_cfg_pkg::NUM_RT_UOP-1:0]    xrf_wr_index,
  output rvv_cfg_pkg::xdata_t    [rvv_cfg_pkg::NUM_RT_UOP-1:0]    xrf_wr_data,
  output logic                                                    vcsr_wr_valid,
  output rvv_cfg_pkg::vcsr_t                                      vcsr_wr_data
);

  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0] retire;  // accepted and not dropped by trap

  assign retire = accept & live;

  always_ff @(posedge clk) begin
    if (reset) begin
      vrf_wr_valid  <= '0;
      xrf_wr_valid  <= '0;
      vcsr_wr_valid <= 1'b0;
    end else begin
      for (int k = 0; k < rvv_cfg_pkg::NUM_RT_UOP; k++) begin
        vrf_wr_valid[k] <= retire[k] && (rob_dest_xrf[k] == rvv_uop_pkg::DEST_VRF);
        xrf_wr_valid[k] <= retire[k] && (rob_dest_xrf[k] == rvv_uop_pkg::DEST_XRF);
      end
      // trapping entry is the youngest live one, so all live must be accepted
      vcsr_wr_valid <= trap_valid && (&(accept | ~live));
    end
  end

  // payload
  always_ff @(posedge clk) begin
    for (int k = 0; k < rvv_cfg_pkg::NUM_RT_UOP; k++) begin
      vrf_wr_index[k]  <= rob_index[k];
      vrf_wr_data[k]   <= rob_data[k];
      vrf_wr_strobe[k] <= strobe[k];
      xrf_wr_index[k]  <= rob_index[k];
      xrf_wr_data[k]   <= rob_data[k][rvv_cfg_pkg::XLEN-1:0];  // low xlen bits
    end
    vcsr_wr_data <= trap_vcsr;
  end

  // vcsr write comes with the trapping entry's own write
  a_vcsr_with_write : assert property (@(posedge clk) disable iff (reset)
    vcsr_wr_valid |-> ((vrf_wr_valid | xrf_wr_valid) != '0));

endmodule

`default_nettype wire

// ==== source/rvv_retire_top.sv ====
/* vector retire stage top
   rob entries in, registered vrf, xrf and vcsr writes out */
`timescale 1ns/10ps
`default_nettype none

module rvv_retire_top (
  input  wire logic                                                clk,
  input  wire logic                                                reset,
  // rob side
  input  wire logic      [rvv_cfg_pkg::NUM_RT_UOP-1:0]             rob_valid,
  input  wire logic      [rvv_cfg_pkg::NUM_RT_UOP-1:0]             rob_dest_xrf,
  input  wire rvv_cfg_pkg::rf_index_t [rvv_cfg_pkg::NUM_RT_UOP-1:0] rob_index,
  input  wire rvv_cfg_pkg::vdata_t    [rvv_cfg_pkg::NUM_RT_UOP-1:0] rob_data,
  input  wire rvv_cfg_pkg::vd_type_t  [rvv_cfg_pkg::NUM_RT_UOP-1:0] rob_vd_type,
  input  wire logic      [rvv_cfg_pkg::NUM_RT_UOP-1:0]             rob_ignore_vta,
  input  wire logic      [rvv_cfg_pkg::NUM_RT_UOP-1:0]             rob_ignore_vma,
  input  wire logic      [rvv_cfg_pkg::NUM_RT_UOP-1:0]             rob_trap,
  input  wire rvv_cfg_pkg::vcsr_t     [rvv_cfg_pkg::NUM_RT_UOP-1:0] rob_vcsr,
  output logic           [rvv_cfg_pkg::NUM_RT_UOP-1:0]             rob_ready,
  // vrf write ports
  output logic           [rvv_cfg_pkg::NUM_RT_UOP-1:0]             vrf_wr_valid,
  output rvv_cfg_pkg::rf_index_t [rvv_cfg_pkg::NUM_RT_UOP-1:0]     vrf_wr_index,
  output rvv_cfg_pkg::vdata_t    [rvv_cfg_pkg::NUM_RT_UOP-1:0]     vrf_wr_data,
  output rvv_cfg_pkg::strobe_t   [rvv_cfg_pkg::NUM_RT_UOP-1:0]     vrf_wr_strobe,
  // xrf write ports, credit flow control
  output logic           [rvv_cfg_pkg::NUM_RT_UOP-1:0]             xrf_wr_valid,
  output rvv_cfg_pkg::rf_index_t [rvv_cfg_pkg::NUM_RT_UOP-1:0]     xrf_wr_index,
  output rvv_cfg_pkg::xdata_t    [rvv_cfg_pkg::NUM_RT_UOP-1:0]     xrf_wr_data,
  input  wire logic                                                xrf_credit_return,
  // vcsr on trap
  output logic                                                     vcsr_wr_valid,
  output rvv_cfg_pkg::vcsr_t                                       vcsr_wr_data
);

  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]               live;
  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]               vrf_write;
  logic                                             trap_valid;
  rvv_cfg_pkg::vcsr_t                               trap_vcsr;
  rvv_cfg_pkg::strobe_t [rvv_cfg_pkg::NUM_RT_UOP-1:0] strobe;

  assign vrf_write = rob_ready & live & ~rob_dest_xrf;  // accepted vector writes only

  retire_trap_filter u_trap (
    .rob_valid  (rob_valid),
    .rob_trap   (rob_trap),
    .rob_vcsr   (rob_vcsr),
    .live       (live),
    .trap_valid (trap_valid),
    .trap_vcsr  (trap_vcsr)
  );

  retire_credit_counter u_credit (
    .clk               (clk),
    .reset             (reset),
    .rob_valid         (rob_valid),
    .live              (live),
    .rob_dest_xrf      (rob_dest_xrf),
    .xrf_credit_return (xrf_credit_return),
    .accept            (rob_ready)
  );

  retire_strobe_gen u_strobe (
    .rob_vd_type    (rob_vd_type),
    .rob_ignore_vta (rob_ignore_vta),
    .rob_ignore_vma (rob_ignore_vma),
    .rob_index      (rob_index),
    .vrf_write      (vrf_write),
    .strobe         (strobe)
  );

  retire_writeback_regs u_wb (
    .clk           (clk),
    .reset         (reset),
    .accept        (rob_ready),
    .live          (live),
    .rob_dest_xrf  (rob_dest_xrf),
    .rob_index     (rob_index),
    .rob_data      (rob_data),
    .strobe        (strobe),
    .trap_valid    (trap_valid),
    .trap_vcsr     (trap_vcsr),
    .vrf_wr_valid  (vrf_wr_valid),
    .vrf_wr_index  (vrf_wr_index),
    .vrf_wr_data   (vrf_wr_data),
    .vrf_wr_strobe (vrf_wr_strobe),
    .xrf_wr_valid  (xrf_wr_valid),
    .xrf_wr_index  (xrf_wr_index),
    .xrf_wr_data   (xrf_wr_data),
    .vcsr_wr_valid (vcsr_wr_valid),
    .vcsr_wr_data  (vcsr_wr_data)
  );

endmodule

`default_nettype wire

// ==== tests/tb_rvv_retire.sv ====
/* testbench for the vector retire stage
   replays retire_input.dat, models credits and checks ready, vrf, xrf and vcsr writes */
`timescale 1ns/10ps
`default_nettype none

module tb_rvv_retire;

  localparam int N          = rvv_cfg_pkg::NUM_RT_UOP;
  localparam int NUM_LINES  = 23;
  localparam int CLK_HALF   = 20;
  localparam int ENTRY_TOP  = 64 * N - 1;    // entry 0 in the upper bits
  localparam int STROBE_TOP = 64 * N + 31;
  localparam int RETURN_BIT = 64 * N + 32;
  localparam int LINE_W     = 64 * N + 40;

  logic                           clk;
  logic                           reset;
  logic [N-1:0]                   rob_valid;
  logic [N-1:0]                   rob_dest_xrf;
  rvv_cfg_pkg::rf_index_t [N-1:0] rob_index;
  rvv_cfg_pkg::vdata_t    [N-1:0] rob_data;
  rvv_cfg_pkg::vd_type_t  [N-1:0] rob_vd_type;
  logic [N-1:0]                   rob_ignore_vta;
  logic [N-1:0]                   rob_ignore_vma;
  logic [N-1:0]                   rob_trap;
  rvv_cfg_pkg::vcsr_t     [N-1:0] rob_vcsr;
  logic [N-1:0]                   rob_ready;
  logic [N-1:0]                   vrf_wr_valid;
  rvv_cfg_pkg::rf_index_t [N-1:0] vrf_wr_index;
  rvv_cfg_pkg::vdata_t    [N-1:0] vrf_wr_data;
  rvv_cfg_pkg::strobe_t   [N-1:0] vrf_wr_strobe;
  logic [N-1:0]                   xrf_wr_valid;
  rvv_cfg_pkg::rf_index_t [N-1:0] xrf_wr_index;
  rvv_cfg_pkg::xdata_t    [N-1:0] xrf_wr_data;
  logic                           xrf_credit_return;
  logic                           vcsr_wr_valid;
  rvv_cfg_pkg::vcsr_t             vcsr_wr_data;

  logic [LINE_W-1:0]              vectors [0:NUM_LINES-1];

  // expected port values one cycle after the current line
  logic [N-1:0]                   exp_vrf_valid;
  logic [N-1:0]                   exp_xrf_valid;
  rvv_cfg_pkg::rf_index_t [N-1:0] exp_index;
  rvv_cfg_pkg::vdata_t    [N-1:0] exp_data;
  rvv_cfg_pkg::strobe_t   [N-1:0] exp_strobe;
  logic                           exp_vcsr_valid;
  rvv_cfg_pkg::vcsr_t             exp_vcsr;
  int                             model_credits;
  int                             value_errors;
  int                             other_errors;

  rvv_retire_top UUT (.*);

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  //////////////////////////////
  // helpers
  //////////////////////////////
  function automatic rvv_cfg_pkg::vdata_t widen_data(input logic [15:0] d);
    return {d, ~d, d ^ 16'h5a5a, d[7:0], d[15:8]};  // 16 bit seed over the vector
  endfunction

  function automatic logic [63:0] entry_of(input logic [LINE_W-1:0] v, input int k);
    return v[ENTRY_TOP - 64*k -: 64];
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("[FAIL] %s expected %h got %h", name, exp, act);
    end
  endtask

  // entry ctl byte is {trap, valid, xrf, vta, vma}
  task automatic apply_line(input logic [LINE_W-1:0] v);
    logic [63:0] e;
    for (int k = 0; k < N; k++) begin
      e = entry_of(v, k);
      rob_trap[k]       <= e[60];
      rob_valid[k]      <= e[59];
      rob_dest_xrf[k]   <= e[58];
      rob_ignore_vta[k] <= e[57];
      rob_ignore_vma[k] <= e[56];
      rob_index[k]      <= e[52:48];
      rob_data[k]       <= widen_data(e[47:32]);
      rob_vd_type[k]    <= e[31:16];
      rob_vcsr[k]       <= e[15:0];
    end
    xrf_credit_return <= v[RETURN_BIT];
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////
  task automatic predict_line(input logic [LINE_W-1:0] v, input int line_no);
    logic [63:0]  e;
    logic [N-1:0] ready;
    logic [N-1:0] live;
    logic         need;
    logic         chain;
    int           trap_at;
    int           used;
    trap_at = -1;
    for (int k = N - 1; k >= 0; k--) begin
      e = entry_of(v, k);
      if (e[59] && e[60]) trap_at = k;  // oldest trap wins
    end
    used  = 0;
    chain = 1'b1;
    for (int k = 0; k < N; k++) begin
      e       = entry_of(v, k);
      live[k] = e[59] && (trap_at < 0 || k <= trap_at);
      need    = live[k] && e[58];
      ready[k] = chain && (!need || used < model_credits);
      if (ready[k] && need) used++;
      chain = ready[k] && e[59];   // in-order retirement
      exp_vrf_valid[k] = ready[k] && live[k] && !e[58];
      exp_xrf_valid[k] = ready[k] && live[k] && e[58];
      exp_index[k]     = e[52:48];
      exp_data[k]      = widen_data(e[47:32]);
      exp_strobe[k]    = v[STROBE_TOP - 8*k -: 8];
    end
    assert (ready == v[LINE_W-1 -: N]) else begin
      other_errors++;
      $display("line %0d: credit model and data file disagree on the ready mask", line_no);
    end
    exp_vcsr_valid = 1'b0;
    exp_vcsr       = '0;
    if (trap_at >= 0) begin
      e              = entry_of(v, trap_at);
      exp_vcsr_valid = ready[trap_at];
      exp_vcsr       = e[15:0];
    end
    model_credits = model_credits - used + int'(v[RETURN_BIT]);
  endtask

  task automatic check_outputs(input logic [N-1:0] ready_exp);
    check_value("rob_ready", ready_exp, rob_ready);
    check_value("vrf_wr_valid", exp_vrf_valid, vrf_wr_valid);
    check_value("xrf_wr_valid", exp_xrf_valid, xrf_wr_valid);
    check_value("vcsr_wr_valid", exp_vcsr_valid, vcsr_wr_valid);
    if (exp_vcsr_valid) check_value("vcsr_wr_data", exp_vcsr, vcsr_wr_data);
    for (int k = 0; k < N; k++) begin
      if (exp_vrf_valid[k]) begin
        check_value($sformatf("vrf_wr_index[%0d]", k), exp_index[k], vrf_wr_index[k]);
        check_value($sformatf("vrf_wr_data[%0d]", k), exp_data[k], vrf_wr_data[k]);
        check_value($sformatf("vrf_wr_strobe[%0d]", k), exp_strobe[k], vrf_wr_strobe[k]);
      end
      if (exp_xrf_valid[k]) begin
        check_value($sformatf("xrf_wr_index[%0d]", k), exp_index[k], xrf_wr_index[k]);
        check_value($sformatf("xrf_wr_data[%0d]", k),
                    exp_data[k][rvv_cfg_pkg::XLEN-1:0], xrf_wr_data[k]);
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    value_errors   = 0;
    other_errors   = 0;
    model_credits  = rvv_cfg_pkg::XRF_CREDITS;
    exp_vrf_valid  = '0;
    exp_xrf_valid  = '0;
    exp_vcsr_valid = 1'b0;
    reset <= 1'b1;
    apply_line('0);
    $readmemh("tests/retire_input.dat", vectors);
    assert (!$isunknown(vectors[NUM_LINES-1]) && vectors[0] != '0) else begin
      other_errors++;
      $display("stimulus file missing or shorter than expected");
    end
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      check_value("vrf_wr_valid", '0, vrf_wr_valid);
      check_value("xrf_wr_valid", '0, xrf_wr_valid);
      check_value("vcsr_wr_valid", '0, vcsr_wr_valid);
    end
    @(posedge clk);  // third reset edge
    reset <= 1'b0;
    for (int i = 0; i < NUM_LINES; i++) begin
      apply_line(vectors[i]);
      @(negedge clk);
      check_outputs(vectors[i][LINE_W-1 -: N]);
      predict_line(vectors[i], i);
      @(posedge clk);
    end
    apply_line('0);
    @(negedge clk);
    check_outputs(N'(1));  // idle rob, only entry 0 ready
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #((NUM_LINES + 10) * 2 * CLK_HALF);
    $display("watchdog expired before the last stimulus line was checked");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/retire_input.dat ====
// ready mask _ credit return _ expected vrf strobes e0..e3 _ then entries e0..e3, each as
// ctl {trap,valid,xrf,vta,vma} _ index _ data seed _ element types _ vcsr
f_0_00000000_0c_01_1111_0000_0000_0c_02_2222_0000_0000_0c_03_3333_0000_0000_0c_04_4444_0000_0000
1_0_ff000000_08_05_aaaa_ffff_0000_0c_06_6666_0000_0000_08_07_7777_00ff_0000_08_08_8888_ff00_0000
0_1_00000000_0c_06_6666_0000_0000_08_07_7777_00ff_0000_08_08_8888_ff00_0000_00_00_0000_0000_0000
f_0_000ff000_0c_06_6666_0000_0000_08_07_7777_00ff_0000_08_08_8888_ff00_0000_00_00_0000_0000_0000
3_1_ff550000_08_09_9999_ffff_0000_08_0a_aaaa_3333_0000_0c_0b_bbbb_0000_0000_0c_0c_cccc_0000_0000
1_1_00000000_0c_0b_bbbb_0000_0000_0c_0c_cccc_0000_0000_0b_0d_dddd_5555_0000_00_00_0000_0000_0000
f_0_00ff55aa_0c_0c_cccc_0000_0000_0b_0d_dddd_5555_0000_0a_0e_eeee_7777_0000_09_0f_ffff_cccc_0000
f_1_00aa0180_08_10_0123_aaaa_0000_08_11_4567_dddd_0000_08_12_89ab_0003_0000_08_13_cdef_c000_0000
f_1_f00fff00_08_14_1010_ffff_0000_08_14_2020_00ff_0000_08_15_3030_ffff_0000_00_00_0000_0000_0000
f_1_0033ccff_0b_16_4040_0000_0000_08_16_5050_0f0f_0000_08_16_6060_f0f0_0000_08_17_7070_ffff_0000
f_0_200a5580_08_18_8080_ffff_0000_08_18_9090_00ff_0000_08_18_a0a0_3333_0000_08_18_b0b0_c000_0000
f_0_fc0003ff_08_19_c0c0_ffff_0000_0c_19_d0d0_0000_0000_08_19_e0e0_000f_0000_08_1a_f0f0_ffff_0000
f_0_ff0f0000_08_01_1357_ffff_0000_18_02_2468_00ff_0a5c_0c_03_3579_0000_0000_08_01_468a_ffff_0000
f_1_00000000_1c_05_abcd_0000_1234_0c_06_0606_0000_0000_1c_07_0707_0000_ffff_0c_08_0808_0000_0000
3_0_00000000_0c_09_0909_0000_0000_0c_0a_0a0a_0000_0000_1c_0b_5a5a_0000_4321_08_0c_0c0c_ffff_0000
0_1_00000000_1c_0b_5a5a_0000_4321_08_0c_0c0c_ffff_0000_00_00_0000_0000_0000_00_00_0000_0000_0000
7_0_00000000_1c_0b_5a5a_0000_4321_08_0c_0c0c_ffff_0000_00_00_0000_0000_0000_00_00_0000_0000_0000
1_1_00000000_00_00_0000_0000_0000_00_00_0000_0000_0000_00_00_0000_0000_0000_00_00_0000_0000_0000
1_1_00000000_00_00_0000_0000_0000_00_00_0000_0000_0000_00_00_0000_0000_0000_00_00_0000_0000_0000
7_1_0000ff00_0c_1f_fedc_0000_0000_0c_1e_ba98_0000_0000_08_1d_7654_ffff_0000_0c_1c_3210_0000_0000
3_1_00000000_0c_1c_3210_0000_0000_00_00_0000_0000_0000_00_00_0000_0000_0000_00_00_0000_0000_0000
3_0_ff000000_08_11_1111_ffff_0000_00_00_0000_0000_0000_08_12_2222_0f0f_0000_00_00_0000_0000_0000
3_1_33000000_08_12_2222_0f0f_0000_0c_13_4444_0000_0000_0c_14_5555_0000_0000_08_12_6666_3333_0000

// ==== project.f ====
source/rvv_cfg_pkg.sv
source/rvv_uop_pkg.sv
source/retire_credit_counter.sv
source/retire_trap_filter.sv
source/retire_strobe_gen.sv
source/retire_writeback_regs.sv
source/rvv_retire_top.sv
tests/tb_rvv_retire.sv

// ==== run_sim.sh ====
#!/bin/sh
# verilator build and run of the retire stage testbench
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rvv_retire -f project.f -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
